// ==== rtl/nfu_cfg_pkg.sv ====
package nfu_cfg_pkg;

    // neuron, synapse and partial sum word width
    localparam int SYN_W = 16;

    // tile sizes
    // neurons per window (tree inputs)
    localparam int NFU_TI = 4;
    // filters
    localparam int NFU_TN = 4;
    // windows processed side by side
    localparam int NFU_TW = 2;

    // precision field, holds 1..16 (0 read as 16)
    localparam int PREC_W = 5;

    // shift-and-add accumulator
    localparam int ACC_W = 32;

    // levels of the adder tree
    localparam int TREE_DEPTH = $clog2(NFU_TI);
    // one extra bit per tree level
    localparam int TREE_GROW = TREE_DEPTH;

    // product width, one extra bit so negating the most negative synapse is exact
    localparam int PROD_W = SYN_W + 1;
    // tree output width
    localparam int TREE_W = PROD_W + TREE_GROW;

endpackage

// ==== rtl/nfu_types_pkg.sv ====
package nfu_types_pkg;

    import nfu_cfg_pkg::*;

    // ti synapses of one filter
    typedef logic [NFU_TI-1:0][SYN_W-1:0] synapse_vec_t;

    // all filters of a job
    typedef synapse_vec_t [NFU_TN-1:0] synapse_grid_t;

    // ti neurons of each window, low P bits significant
    typedef logic [NFU_TW-1:0][NFU_TI-1:0][SYN_W-1:0] neuron_grid_t;

    // one word per (window, filter), window-major
    typedef logic [NFU_TW-1:0][NFU_TN-1:0][SYN_W-1:0] out_grid_t;

    // one serial bit per neuron of each window
    typedef logic [NFU_TW-1:0][NFU_TI-1:0] bit_grid_t;

    // complete job as handed in
    typedef struct packed {
        neuron_grid_t neurons;
        synapse_grid_t synapses;
        // partial sums from the output buffer
        out_grid_t nbout;
        logic [PREC_W-1:0] precision;
        // pooling, signed max instead of sum
        logic max_mode;
    } nfu_job_t;

    // finished outputs of the tile
    typedef struct packed {
        out_grid_t words;
    } nfu_result_t;

    // per-cycle lane control
    typedef struct packed {
        // a neuron bit is on the lane inputs
        logic bit_valid;
        // sign bit, products get negated
        logic first;
        // lsb of the neuron
        logic last;
    } lane_ctl_t;

endpackage

// ==== rtl/serial_adder_tree.sv ====
`timescale 1ns/1ps

module serial_adder_tree #(
    parameter int IN_W = 17,
    parameter int N_IN = 4
) (
    input logic clk,
    input logic signed [IN_W-1:0] i_vals [N_IN],
    output logic signed [IN_W+nfu_cfg_pkg::TREE_GROW-1:0] o_sum
);

    import nfu_cfg_pkg::*;

    // number of pairwise levels
    localparam int LVLS = $clog2(N_IN);

    genvar l;
    genvar j;

    // level 0 holds the inputs, level l holds N_IN >> l values of IN_W + l bits
    for (l = 0; l <= LVLS; l++) begin : g_lvl
        localparam int LW = IN_W + l;
        localparam int CNT = N_IN >> l;

        logic signed [LW-1:0] val [CNT];

        if (l == 0) begin : g_in
            for (j = 0; j < CNT; j++) begin : g_word
                assign val[j] = i_vals[j];
            end
        end else begin : g_add
            logic signed [LW-1:0] sum [CNT];

            // pairwise add, both operands sign extended by one bit
            for (j = 0; j < CNT; j++) begin : g_pair
                assign sum[j] = LW'(g_lvl[l-1].val[2*j]) + LW'(g_lvl[l-1].val[2*j+1]);
            end

            if (l == 1) begin : g_reg
                // pipeline cut after the first level
                always_ff @(posedge clk) begin
                    val <= sum;
                end
            end else begin : g_comb
                // later levels settle within the next cycle
                assign val = sum;
            end
        end
    end

    // root of the tree
    assign o_sum = (IN_W + TREE_GROW)'(g_lvl[LVLS].val[0]);

endmodule

// ==== rtl/serial_ip_lane.sv ====
`timescale 1ns/1ps

module serial_ip_lane (
    input logic clk,
    input logic reset,
    input nfu_types_pkg::lane_ctl_t i_ctl,
    input logic [nfu_cfg_pkg::NFU_TI-1:0] i_bits,
    input nfu_types_pkg::synapse_vec_t i_synapses,
    input logic [nfu_cfg_pkg::SYN_W-1:0] i_nbout,
    input logic i_max_mode,
    output logic [nfu_cfg_pkg::SYN_W-1:0] o_out
);

    import nfu_cfg_pkg::*;
    import nfu_types_pkg::*;

    logic signed [PROD_W-1:0] prod [NFU_TI];
    logic signed [TREE_W-1:0] tree_sum;
    logic signed [ACC_W-1:0] tree_ext;
    logic signed [ACC_W-1:0] acc_q;
    logic [SYN_W-1:0] acc_lo;
    lane_ctl_t ctl_q;

    genvar gi;

    // 1-bit products, negated for the sign bit
    for (gi = 0; gi < NFU_TI; gi++) begin : g_prod
        logic signed [PROD_W-1:0] syn_ext;

        assign syn_ext = PROD_W'($signed(i_synapses[gi]));
        assign prod[gi] = !i_bits[gi] ? '0 : (i_ctl.first ? -syn_ext : syn_ext);
    end

    serial_adder_tree #(
        .IN_W(PROD_W),
        .N_IN(NFU_TI)
    ) u_tree (
        .clk(clk),
        .i_vals(prod),
        .o_sum(tree_sum)
    );

    // control lags by one to line up with the tree register
    always_ff @(posedge clk) begin
        if (reset) begin
            ctl_q <= '0;
        end else begin
            ctl_q <= i_ctl;
        end
    end

    assign tree_ext = ACC_W'(tree_sum);

    // shift-and-add, msb first
    // sign bit restarts the sum
    always_ff @(posedge clk) begin
        if (ctl_q.bit_valid) begin
            if (ctl_q.first) begin
                acc_q <= tree_ext;
            end else begin
                acc_q <= tree_ext + (acc_q <<< 1);
            end
        end
    end

    assign acc_lo = acc_q[SYN_W-1:0];

    // partial sum joins after accumulation
    always_comb begin
        if (i_max_mode) begin
            // pooling, signed compare of the low words
            o_out = ($signed(acc_lo) > $signed(i_nbout)) ? acc_lo : i_nbout;
        end else begin
            // wraps modulo 2^16
            o_out = acc_lo + i_nbout;
        end
    end

endmodule

// ==== rtl/bit_counter.sv ====
`timescale 1ns/1ps

module bit_counter (
    input logic clk,
    input logic reset,
    input logic i_load,
    input logic [nfu_cfg_pkg::PREC_W-1:0] i_precision,
    input logic i_step,
    output logic o_first,
    output logic o_last
);

    import nfu_cfg_pkg::*;

    // bits still to be issued, including the current one
    logic [PREC_W-1:0] remain_q;
    logic first_q;
    logic [PREC_W-1:0] prec_eff;

    // zero means full width
    assign prec_eff = (i_precision == '0) ? PREC_W'(SYN_W) : i_precision;

    always_ff @(posedge clk) begin
        if (reset) begin
            remain_q <= '0;
            first_q <= 1'b0;
        end else if (i_load) begin
            remain_q <= prec_eff;
            first_q <= 1'b1;
        end else if (i_step) begin
            remain_q <= remain_q - 1'b1;
            first_q <= 1'b0;
        end
    end

    // sign bit pending
    assign o_first = first_q;
    // P = 1 raises both flags together
    assign o_last = (remain_q == PREC_W'(1));

endmodule

// ==== rtl/nfu_controller.sv ====
`timescale 1ns/1ps

module nfu_controller (
    input logic clk,
    input logic reset,
    input logic i_job_valid,
    input logic i_res_ready,
    input logic i_first,
    input logic i_last,
    output logic o_job_ready,
    output logic o_res_valid,
    output logic o_load,
    output logic o_step,
    output nfu_types_pkg::lane_ctl_t o_lane_ctl
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STREAM,
        ST_DRAIN,
        ST_HOLD
    } state_t;

    state_t state_q;
    state_t state_d;
    // high in the second drain cycle
    logic drain_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
            drain_q <= 1'b0;
        end else begin
            state_q <= state_d;
            drain_q <= (state_q == ST_DRAIN) && !drain_q;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_job_valid) begin
                    state_d = ST_STREAM;
                end
            end
            // one neuron bit per cycle
            ST_STREAM: begin
                if (i_last) begin
                    state_d = ST_DRAIN;
                end
            end
            // tree register, then accumulator
            ST_DRAIN: begin
                if (drain_q) begin
                    state_d = ST_HOLD;
                end
            end
            // result held until taken
            ST_HOLD: begin
                if (i_res_ready) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    // one job in flight
    assign o_job_ready = (state_q == ST_IDLE);
    assign o_load = o_job_ready && i_job_valid;
    assign o_step = (state_q == ST_STREAM);
    assign o_res_valid = (state_q == ST_HOLD);

    // lanes only see bits while streaming
    always_comb begin
        o_lane_ctl.bit_valid = o_step;
        o_lane_ctl.first = o_step && i_first;
        o_lane_ctl.last = o_step && i_last;
    end

endmodule

// ==== rtl/neuron_serializer.sv ====
`timescale 1ns/1ps

module neuron_serializer (
    input logic clk,
    input logic reset,
    input logic i_load,
    input nfu_types_pkg::neuron_grid_t i_neurons,
    input logic [nfu_cfg_pkg::PREC_W-1:0] i_precision,
    input logic i_step,
    output nfu_types_pkg::bit_grid_t o_bits
);

    import nfu_cfg_pkg::*;
    import nfu_types_pkg::*;

    neuron_grid_t sh_q;
    // left shift that puts the sign bit at the msb
    logic [PREC_W-1:0] shamt;

    // precision 0 stands for 16, no shift
    assign shamt = (i_precision == '0) ? '0 : PREC_W'(SYN_W) - i_precision;

    always_ff @(posedge clk) begin
        if (reset) begin
            sh_q <= '0;
        end else if (i_load) begin
            for (int w = 0; w < NFU_TW; w++) begin
                for (int i = 0; i < NFU_TI; i++) begin
                    sh_q[w][i] <= i_neurons[w][i] << shamt;
                end
            end
        end else if (i_step) begin
            // next lower bit moves up
            for (int w = 0; w < NFU_TW; w++) begin
                for (int i = 0; i < NFU_TI; i++) begin
                    sh_q[w][i] <= sh_q[w][i] << 1;
                end
            end
        end
    end

    // msb of every word
    always_comb begin
        for (int w = 0; w < NFU_TW; w++) begin
            for (int i = 0; i < NFU_TI; i++) begin
                o_bits[w][i] = sh_q[w][i][SYN_W-1];
            end
        end
    end

endmodule

// ==== rtl/nfu_serial_top.sv ====
`timescale 1ns/1ps

module nfu_serial_top (
    input logic clk,
    input logic reset,
    input nfu_types_pkg::nfu_job_t i_job,
    input logic i_job_valid,
    output logic o_job_ready,
    output nfu_types_pkg::nfu_result_t o_res,
    output logic o_res_valid,
    input logic i_res_ready
);

    import nfu_cfg_pkg::*;
    import nfu_types_pkg::*;

    logic load;
    logic step;
    logic first;
    logic last;
    lane_ctl_t lane_ctl;
    bit_grid_t ser_bits;

    // job fields used for the whole job
    synapse_grid_t syn_q;
    out_grid_t nbout_q;
    logic max_q;
    out_grid_t lane_out;

    nfu_controller u_ctrl (
        .clk(clk),
        .reset(reset),
        .i_job_valid(i_job_valid),
        .i_res_ready(i_res_ready),
        .i_first(first),
        .i_last(last),
        .o_job_ready(o_job_ready),
        .o_res_valid(o_res_valid),
        .o_load(load),
        .o_step(step),
        .o_lane_ctl(lane_ctl)
    );

    bit_counter u_cnt (
        .clk(clk),
        .reset(reset),
        .i_load(load),
        .i_precision(i_job.precision),
        .i_step(step),
        .o_first(first),
        .o_last(last)
    );

    neuron_serializer u_ser (
        .clk(clk),
        .reset(reset),
        .i_load(load),
        .i_neurons(i_job.neurons),
        .i_precision(i_job.precision),
        .i_step(step),
        .o_bits(ser_bits)
    );

    // captured on acceptance
    always_ff @(posedge clk) begin
        if (load) begin
            syn_q <= i_job.synapses;
            nbout_q <= i_job.nbout;
            max_q <= i_job.max_mode;
        end
    end

    genvar w;
    genvar n;

    // lane (w, n): window w bits against filter n
    for (w = 0; w < NFU_TW; w++) begin : g_win
        for (n = 0; n < NFU_TN; n++) begin : g_flt
            serial_ip_lane u_lane (
                .clk(clk),
                .reset(reset),
                .i_ctl(lane_ctl),
                .i_bits(ser_bits[w]),
                .i_synapses(syn_q[n]),
                .i_nbout(nbout_q[w][n]),
                .i_max_mode(max_q),
                .o_out(lane_out[w][n])
            );
        end
    end

    assign o_res.words = lane_out;

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
    output logic o_clk,
    output logic o_reset
);

    // half of the 40 ns period
    localparam int HALF_NS = 20;

    initial begin
        o_clk = 1'b0;
        forever begin
            #HALF_NS o_clk = ~o_clk;
        end
    end

    // three rising edges of reset, released with the stimulus offset
    initial begin
        o_reset = 1'b1;
        repeat (3) @(posedge o_clk);
        #5;
        o_reset = 1'b0;
    end

endmodule

// ==== bench/tb_nfu_serial.sv ====
`timescale 1ns/1ps

module tb_nfu_serial;

    import nfu_cfg_pkg::*;
    import nfu_types_pkg::*;

    localparam int RES_BITS = $bits(nfu_result_t);
    // jobs over all tests below
    localparam int TOTAL_JOBS = 44;
    // longest hold stretch plus the cycle that raises ready
    localparam int MAX_STALL = 8;
    localparam int JOB_CYCLES = SYN_W + 2 + MAX_STALL + 4;
    localparam int WATCHDOG_NS = (TOTAL_JOBS * JOB_CYCLES + 20) * 40;

    logic clk;
    logic reset;
    nfu_job_t i_job;
    logic i_job_valid;
    logic o_job_ready;
    nfu_result_t o_res;
    logic o_res_valid;
    logic i_res_ready;

    logic [31:0] lfsr_state = 32'h828450b4;
    int edge_cnt = 0;
    int accept_edge;
    int acc_cnt;

    // prepared per test and consumed in order
    nfu_job_t jobs[$];
    nfu_result_t exps[$];
    int precs[$];
    int stalls[$];

    clk_gen u_clk (
        .o_clk(clk),
        .o_reset(reset)
    );

    nfu_serial_top u_dut (
        .clk(clk),
        .reset(reset),
        .i_job(i_job),
        .i_job_valid(i_job_valid),
        .o_job_ready(o_job_ready),
        .o_res(o_res),
        .o_res_valid(o_res_valid),
        .i_res_ready(i_res_ready)
    );

    // rising edge count sampled at falling edges
    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < nbits; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [SYN_W-1:0] rand_word();
        logic [31:0] v;
        v = rand_bits(SYN_W);
        return v[SYN_W-1:0];
    endfunction

    // sum over i of synapse times sign-extended P-bit neuron before the sum or max rule
    function automatic nfu_result_t ref_result(input nfu_job_t job);
        nfu_result_t res;
        longint acc;
        longint nv;
        longint sv;
        longint mask;
        int p;
        logic [SYN_W-1:0] lo;
        p = (job.precision == '0) ? SYN_W : int'(job.precision);
        mask = (longint'(1) << p) - 1;
        for (int w = 0; w < NFU_TW; w++) begin
            for (int n = 0; n < NFU_TN; n++) begin
                acc = 0;
                for (int i = 0; i < NFU_TI; i++) begin
                    nv = longint'(job.neurons[w][i]) & mask;
                    // upper half of the P-bit range is negative
                    if (nv >= (longint'(1) << (p - 1))) begin
                        nv = nv - (longint'(1) << p);
                    end
                    sv = longint'($signed(job.synapses[n][i]));
                    acc = acc + nv * sv;
                end
                lo = acc[SYN_W-1:0];
                if (job.max_mode) begin
                    res.words[w][n] = ($signed(lo) > $signed(job.nbout[w][n])) ?
                        lo : job.nbout[w][n];
                end else begin
                    res.words[w][n] = lo + job.nbout[w][n];
                end
            end
        end
        return res;
    endfunction

    task automatic check_val(input string name, input logic [RES_BITS-1:0] expected,
                             input logic [RES_BITS-1:0] actual);
        if (expected !== actual) begin
            $display("ERROR: %s expected %0h actual %0h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // extreme jobs carry the most negative neuron and synapse values
    task automatic build_job(input int p, input bit mx, input bit extreme,
                             output nfu_job_t job);
        logic [SYN_W-1:0] pmask;
        pmask = SYN_W'((32'h1 << p) - 1);
        for (int w = 0; w < NFU_TW; w++) begin
            for (int i = 0; i < NFU_TI; i++) begin
                // bits above P are junk the DUT must ignore
                job.neurons[w][i] = rand_word();
                if (extreme) begin
                    job.neurons[w][i] = (job.neurons[w][i] & ~pmask) | (SYN_W'(1) << (p - 1));
                end
            end
            for (int n = 0; n < NFU_TN; n++) begin
                job.nbout[w][n] = rand_word();
            end
        end
        for (int n = 0; n < NFU_TN; n++) begin
            for (int i = 0; i < NFU_TI; i++) begin
                job.synapses[n][i] = (extreme && i == 0) ? 16'h8000 : rand_word();
            end
        end
        job.precision = PREC_W'(p);
        job.max_mode = mx;
    endtask

    // next job goes up right after acceptance
    task automatic drive_jobs(input int njobs);
        bit ready_seen;
        for (int k = 0; k < njobs; k++) begin
            i_job = jobs[k];
            i_job_valid = 1'b1;
            ready_seen = 1'b0;
            while (!ready_seen) begin
                @(negedge clk);
                if (o_job_ready) begin
                    ready_seen = 1'b1;
                end else begin
                    @(posedge clk);
                    #5;
                end
            end
            // transfer on the coming edge
            accept_edge = edge_cnt + 1;
            acc_cnt = acc_cnt + 1;
            @(posedge clk);
            #5;
        end
        i_job_valid = 1'b0;
    endtask

    // compares one result per accepted job in order
    task automatic collect_results(input string tname, input int njobs, input bit bp);
        nfu_result_t held;
        string nm;
        for (int k = 0; k < njobs; k++) begin
            nm = $sformatf("%s job %0d", tname, k);
            @(negedge clk);
            while (!o_res_valid) begin
                @(posedge clk);
                #5;
                @(negedge clk);
            end
            check_val({nm, " accept count"}, RES_BITS'(k + 1), RES_BITS'(acc_cnt));
            check_val({nm, " latency"}, RES_BITS'(precs[k] + 2),
                      RES_BITS'(edge_cnt - accept_edge));
            held = o_res;
            if (bp) begin
                // result must freeze while ready is low
                for (int s = 0; s < stalls[k]; s++) begin
                    @(posedge clk);
                    #5;
                    @(negedge clk);
                    check_val({nm, " valid held"}, RES_BITS'(1), RES_BITS'(o_res_valid));
                    check_val({nm, " data held"}, held, o_res);
                    check_val({nm, " job ready low"}, RES_BITS'(0), RES_BITS'(o_job_ready));
                end
                @(posedge clk);
                #5;
                i_res_ready = 1'b1;
                @(negedge clk);
                check_val({nm, " valid held"}, RES_BITS'(1), RES_BITS'(o_res_valid));
                check_val({nm, " data held"}, held, o_res);
            end
            for (int w = 0; w < NFU_TW; w++) begin
                for (int n = 0; n < NFU_TN; n++) begin
                    check_val($sformatf("%s w%0d n%0d", nm, w, n),
                              RES_BITS'(exps[k].words[w][n]), RES_BITS'(o_res.words[w][n]));
                end
            end
            // taken on this edge
            @(posedge clk);
            #5;
            i_res_ready = !bp;
            @(negedge clk);
            check_val({nm, " valid dropped"}, RES_BITS'(0), RES_BITS'(o_res_valid));
            check_val({nm, " job ready back"}, RES_BITS'(1), RES_BITS'(o_job_ready));
            @(posedge clk);
            #5;
        end
    endtask

    // prec 0 picks 1..16 per job
    // mode 2 picks sum or max per job
    task automatic run_test(input string tname, input int njobs, input int prec,
                            input int mode, input bit extreme, input bit bp);
        nfu_job_t job;
        logic [31:0] r;
        int p;
        bit mx;
        jobs.delete();
        exps.delete();
        precs.delete();
        stalls.delete();
        acc_cnt = 0;
        for (int k = 0; k < njobs; k++) begin
            r = rand_bits(4);
            p = (prec == 0) ? int'(r[3:0]) + 1 : prec;
            r = rand_bits(1);
            mx = (mode == 2) ? r[0] : (mode == 1);
            build_job(p, mx, extreme && (k % 2 == 1), job);
            jobs.push_back(job);
            exps.push_back(ref_result(job));
            precs.push_back(p);
            r = rand_bits(3);
            stalls.push_back(bp ? int'(r[2:0]) : 0);
        end
        i_res_ready = !bp;
        fork
            drive_jobs(njobs);
            collect_results(tname, njobs, bp);
        join
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("simulation timed out before all jobs completed");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        i_job = '0;
        i_job_valid = 1'b0;
        i_res_ready = 1'b0;
        @(negedge reset);
        @(negedge clk);
        check_val("reset res valid", RES_BITS'(0), RES_BITS'(o_res_valid));
        check_val("reset job ready", RES_BITS'(1), RES_BITS'(o_job_ready));
        @(posedge clk);
        #5;
        run_test("sum_p16", 8, 16, 0, 1'b0, 1'b0);
        run_test("prec_1", 4, 1, 0, 1'b1, 1'b0);
        run_test("prec_4", 4, 4, 0, 1'b1, 1'b0);
        run_test("prec_8", 4, 8, 0, 1'b1, 1'b0);
        run_test("prec_13", 4, 13, 0, 1'b1, 1'b0);
        run_test("max_mode", 8, 0, 1, 1'b0, 1'b0);
        run_test("back_pressure", 12, 0, 2, 1'b1, 1'b1);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
rtl/nfu_cfg_pkg.sv
rtl/nfu_types_pkg.sv
rtl/serial_adder_tree.sv
rtl/serial_ip_lane.sv
rtl/bit_counter.sv
rtl/nfu_controller.sv
rtl/neuron_serializer.sv
rtl/nfu_serial_top.sv
bench/clk_gen.sv
bench/tb_nfu_serial.sv

// ==== run.sh ====
#!/bin/sh
# build and run the NFU tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_nfu_serial -f compile.f --Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_nfu_serial)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi

echo "pass message not found"
exit 1
